/* common/wb_bus_pkg.sv */
`default_nettype none

package wb_bus_pkg;

  // bus field widths
  typedef logic [31:0] wb_adr_t;   // byte address
  typedef logic [15:0] wb_dat_t;   // data word
  typedef logic [1:0]  wb_sel_t;   // byte lane selects

  // upper address half, compared by the decoder
  typedef logic [15:0] wb_page_t;

  // number of slots in the address map
  localparam int NUM_WINDOWS = 3;

  typedef logic [1:0] slave_idx_t;  // slave number

  // window map, one entry per slot, bounds inclusive
  //   slot 0: page 0x0000
  //   slot 1: page 0x0001
  //   slot 2: pages 0x0002 and 0x0003, the second one aliases the first
  localparam wb_page_t [NUM_WINDOWS-1:0] WIN_BASE = {
    16'h0002,
    16'h0001,
    16'h0000
  };

  localparam wb_page_t [NUM_WINDOWS-1:0] WIN_HIGH = {
    16'h0003,
    16'h0001,
    16'h0000
  };

endpackage

`default_nettype wire

/* project.f */
common/wb_bus_pkg.sv
src/bus_watchdog.sv
wb_decoder/addr_window_match.sv
wb_decoder/wb_decoder.sv
src/wb_reg_slave.sv
src/wb_bus_top.sv
sim/tb_wb_bus.sv

/* run_sim.sh */
#!/bin/sh
# build and run the Wishbone fabric testbench with Verilator

cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module tb_wb_bus -f project.f &&
out="$(./obj_dir/Vtb_wb_bus)" ;
echo "$out" ;
echo "$out" | grep -qx "Finished with no errors" && echo "PASS" || {
  echo "FAIL"
  exit 1
}

/* sim/tb_wb_bus.sv */
`default_nettype none

module tb_wb_bus
  import wb_bus_pkg::*;
();

  localparam int TIMEOUT     = 12;   // matches the DUT default
  localparam int CLK_PERIOD  = 20;
  localparam int DRIVE_DLY   = 2;
  localparam int N_TRANSFERS = 276;
  localparam int RUN_LIMIT   = (N_TRANSFERS + 4) * (TIMEOUT + 10) * CLK_PERIOD;

  logic    wb_clk_i;
  logic    wb_rst_i;
  logic    wbm_cyc_i;
  logic    wbm_stb_i;
  logic    wbm_we_i;
  wb_sel_t wbm_sel_i;
  wb_adr_t wbm_adr_i;
  wb_dat_t wbm_dat_i;
  wb_dat_t wbm_dat_o;
  logic    wbm_ack_o;
  logic    wbm_err_o;

  wb_dat_t     model [NUM_WINDOWS][16];  // expected contents per slot
  int          n_checks;
  int          n_errors;
  int          test_err_base;
  logic [31:0] rng;

  wb_bus_top i_dut (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wbm_cyc_i (wbm_cyc_i),
    .wbm_stb_i (wbm_stb_i),
    .wbm_we_i  (wbm_we_i),
    .wbm_sel_i (wbm_sel_i),
    .wbm_adr_i (wbm_adr_i),
    .wbm_dat_i (wbm_dat_i),
    .wbm_dat_o (wbm_dat_o),
    .wbm_ack_o (wbm_ack_o),
    .wbm_err_o (wbm_err_o)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;
  end

  a_resp_excl : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !(wbm_ack_o && wbm_err_o))
    else begin
      n_errors++;
      $display("ack and err were high together at time %0t", $time);
    end

  // a response only answers a cycle the master held open
  a_resp_in_cycle : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (wbm_ack_o || wbm_err_o) |-> $past(wbm_cyc_i))
    else begin
      n_errors++;
      $display("response seen with no open cycle at time %0t", $time);
    end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // lowest slot whose window holds the page, -1 if none
  function automatic int page_slot(input wb_page_t page);
    int slot;
    slot = -1;
    for (int i = 0; i < NUM_WINDOWS; i++) begin
      if (slot < 0 && page >= WIN_BASE[i] && page <= WIN_HIGH[i]) begin
        slot = i;
      end
    end
    return slot;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    n_checks++;
    assert (got === exp)
      else begin
        n_errors++;
        $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
      end
  endtask

  task automatic report_test(input string name);
    $display("test %s done, %0d errors", name, n_errors - test_err_base);
    test_err_base = n_errors;
  endtask

  // one master cycle, checked against the model
  task automatic access(input logic we, input wb_sel_t sel, input wb_adr_t adr,
                        input wb_dat_t wdat, output wb_dat_t rdat);
    int   slot;
    int   idx;
    int   waited;
    logic got_ack;
    logic got_err;
    slot      = page_slot(adr[31:16]);
    idx       = int'(adr[4:1]);   // upper bits alias
    wbm_cyc_i = 1'b1;
    wbm_stb_i = 1'b1;
    wbm_we_i  = we;
    wbm_sel_i = sel;
    wbm_adr_i = adr;
    wbm_dat_i = wdat;
    waited    = 0;
    got_ack   = 1'b0;
    got_err   = 1'b0;
    while (!got_ack && !got_err && waited < TIMEOUT + 10) begin
      @(posedge wb_clk_i);
      #DRIVE_DLY;
      got_ack = wbm_ack_o;
      got_err = wbm_err_o;
      waited++;
    end
    rdat      = wbm_dat_o;
    wbm_cyc_i = 1'b0;
    wbm_stb_i = 1'b0;
    wbm_we_i  = 1'b0;
    if (!got_ack && !got_err) begin
      n_errors++;
      $display("no ack or err for address %h after %0d cycles", adr, waited);
    end else if (slot < 0) begin
      check_value("ack on unmapped address", 32'(got_ack), 32'd0);
      check_value("err on unmapped address", 32'(got_err), 32'd1);
    end else begin
      check_value("ack on mapped address", 32'(got_ack), 32'd1);
      check_value("err on mapped address", 32'(got_err), 32'd0);
      if (we) begin
        for (int b = 0; b < 2; b++) begin
          if (sel[b]) model[slot][idx][8*b +: 8] = wdat[8*b +: 8];
        end
      end else begin
        check_value("read data", 32'(rdat), 32'(model[slot][idx]));
      end
    end
    @(posedge wb_clk_i);  // idle cycle between requests
    #DRIVE_DLY;
  endtask

  initial begin
    wb_dat_t rd;
    wb_adr_t adr;
    wb_dat_t wd;
    logic    we;
    wb_sel_t sel;
    wb_rst_i      = 1'b1;
    wbm_cyc_i     = 1'b0;
    wbm_stb_i     = 1'b0;
    wbm_we_i      = 1'b0;
    wbm_sel_i     = '0;
    wbm_adr_i     = '0;
    wbm_dat_i     = '0;
    n_checks      = 0;
    n_errors      = 0;
    test_err_base = 0;
    rng           = 32'd96773;
    for (int s = 0; s < NUM_WINDOWS; s++) begin
      for (int w = 0; w < 16; w++) model[s][w] = '0;
    end
    repeat (3) @(posedge wb_clk_i);
    #DRIVE_DLY;
    wb_rst_i = 1'b0;

    check_value("ack after reset", 32'(wbm_ack_o), 32'd0);
    check_value("err after reset", 32'(wbm_err_o), 32'd0);
    for (int s = 0; s < NUM_WINDOWS; s++) begin
      for (int w = 0; w < 16; w++) begin
        access(1'b0, 2'b11, {WIN_BASE[s], 16'(w * 2)}, '0, rd);
        check_value("reset contents", 32'(rd), 32'd0);
      end
    end
    report_test("reset");

    for (int s = 0; s < NUM_WINDOWS; s++) begin
      wd = 16'hC0DE ^ 16'(s * 16'h0111);
      access(1'b1, 2'b11, {WIN_BASE[s], 16'h0006}, wd, rd);
      access(1'b0, 2'b11, {WIN_BASE[s], 16'h0006}, '0, rd);
      check_value("full word readback", 32'(rd), 32'(wd));
    end
    report_test("full_word");

    for (int s = 0; s < NUM_WINDOWS; s++) begin
      adr = {WIN_BASE[s], 16'h000A};
      access(1'b1, 2'b11, adr, 16'h1234, rd);
      access(1'b1, 2'b01, adr, 16'hEECD, rd);   // low byte only
      access(1'b0, 2'b11, adr, '0, rd);
      access(1'b1, 2'b10, adr, 16'h5A00, rd);   // high byte only
      access(1'b0, 2'b11, adr, '0, rd);
      check_value("byte lane result", 32'(rd), 32'h5ACD);
    end
    report_test("byte_lanes");

    access(1'b1, 2'b11, 32'h0002_0004, 16'h7E81, rd);
    access(1'b0, 2'b11, 32'h0003_0004, '0, rd);
    check_value("alias page readback", 32'(rd), 32'h7E81);
    access(1'b0, 2'b11, 32'h0003_0024, '0, rd);
    check_value("alias upper bits readback", 32'(rd), 32'h7E81);
    report_test("alias");

    access(1'b0, 2'b11, 32'h0004_0000, '0, rd);
    access(1'b1, 2'b11, 32'h0004_0002, 16'hFFFF, rd);
    access(1'b0, 2'b11, 32'h0100_0010, '0, rd);
    access(1'b0, 2'b01, 32'hFFFF_FFFE, '0, rd);
    report_test("unmapped");

    for (int n = 0; n < 200; n++) begin
      rng = xorshift32(rng);
      adr = {14'd0, rng[1:0], rng[20:6], 1'b0};   // pages 0 to 3
      we  = rng[21];
      sel = rng[23:22];
      rng = xorshift32(rng);
      wd  = rng[15:0];
      access(we, sel, adr, wd, rd);
    end
    report_test("random");

    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    #(RUN_LIMIT);
    $display("run stopped after %0d time units, a transfer never completed", RUN_LIMIT);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

/* src/bus_watchdog.sv */
`default_nettype none

module bus_watchdog #(
  parameter int TIMEOUT = 12
) (
  input  wire  wb_clk_i,
  input  wire  wb_rst_i,
  input  wire  clear_i,
  output logic expired_o
);

  localparam int CNT_W = $clog2(TIMEOUT + 1);

  logic [CNT_W-1:0] cnt;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || clear_i) begin
      cnt <= '0;
    end else if (cnt != CNT_W'(TIMEOUT)) begin
      cnt <= cnt + 1'b1;  // saturates at TIMEOUT
    end
  end

  assign expired_o = (cnt == CNT_W'(TIMEOUT));

  a_no_rise_on_clear : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    clear_i |-> !$rose(expired_o));

endmodule

`default_nettype wire

/* src/wb_bus_top.sv */
`default_nettype none

module wb_bus_top
  import wb_bus_pkg::*;
#(
  parameter int TIMEOUT    = 12,
  parameter int ACK_DELAY0 = 1,
  parameter int ACK_DELAY1 = 2,
  parameter int ACK_DELAY2 = 4
) (
  input  wire          wb_clk_i,
  input  wire          wb_rst_i,
  input  wire          wbm_cyc_i,
  input  wire          wbm_stb_i,
  input  wire          wbm_we_i,
  input  wire wb_sel_t wbm_sel_i,
  input  wire wb_adr_t wbm_adr_i,
  input  wire wb_dat_t wbm_dat_i,
  output wb_dat_t      wbm_dat_o,
  output logic         wbm_ack_o,
  output logic         wbm_err_o
);

  logic [NUM_WINDOWS-1:0]   wbs_cyc;
  logic [NUM_WINDOWS-1:0]   wbs_stb;
  logic                     wbs_we;
  wb_sel_t                  wbs_sel;
  wb_adr_t                  wbs_adr;   // already rebased
  wb_dat_t                  wbs_wdat;
  wb_dat_t [NUM_WINDOWS-1:0] wbs_rdat;
  logic [NUM_WINDOWS-1:0]   wbs_ack;

  wb_decoder #(
    .NUM_SLAVES (NUM_WINDOWS),
    .TIMEOUT    (TIMEOUT)
  ) i_decoder (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wbm_cyc_i (wbm_cyc_i),
    .wbm_stb_i (wbm_stb_i),
    .wbm_we_i  (wbm_we_i),
    .wbm_sel_i (wbm_sel_i),
    .wbm_adr_i (wbm_adr_i),
    .wbm_dat_i (wbm_dat_i),
    .wbm_dat_o (wbm_dat_o),
    .wbm_ack_o (wbm_ack_o),
    .wbm_err_o (wbm_err_o),
    .wbs_cyc_o (wbs_cyc),
    .wbs_stb_o (wbs_stb),
    .wbs_we_o  (wbs_we),
    .wbs_sel_o (wbs_sel),
    .wbs_adr_o (wbs_adr),
    .wbs_dat_o (wbs_wdat),
    .wbs_dat_i (wbs_rdat),
    .wbs_ack_i (wbs_ack)
  );

  // slot 0, fastest answer
  wb_reg_slave #(.ACK_DELAY(ACK_DELAY0)) i_slave0 (
    .wb_clk_i (wb_clk_i),     .wb_rst_i (wb_rst_i),
    .wbs_cyc_i(wbs_cyc[0]),   .wbs_stb_i(wbs_stb[0]),
    .wbs_we_i (wbs_we),       .wbs_sel_i(wbs_sel),
    .wbs_adr_i(wbs_adr),      .wbs_dat_i(wbs_wdat),
    .wbs_dat_o(wbs_rdat[0]),  .wbs_ack_o(wbs_ack[0])
  );

  wb_reg_slave #(.ACK_DELAY(ACK_DELAY1)) i_slave1 (
    .wb_clk_i (wb_clk_i),     .wb_rst_i (wb_rst_i),
    .wbs_cyc_i(wbs_cyc[1]),   .wbs_stb_i(wbs_stb[1]),
    .wbs_we_i (wbs_we),       .wbs_sel_i(wbs_sel),
    .wbs_adr_i(wbs_adr),      .wbs_dat_i(wbs_wdat),
    .wbs_dat_o(wbs_rdat[1]),  .wbs_ack_o(wbs_ack[1])
  );

  // slot 2 covers two pages
  wb_reg_slave #(.ACK_DELAY(ACK_DELAY2)) i_slave2 (
    .wb_clk_i (wb_clk_i),     .wb_rst_i (wb_rst_i),
    .wbs_cyc_i(wbs_cyc[2]),   .wbs_stb_i(wbs_stb[2]),
    .wbs_we_i (wbs_we),       .wbs_sel_i(wbs_sel),
    .wbs_adr_i(wbs_adr),      .wbs_dat_i(wbs_wdat),
    .wbs_dat_o(wbs_rdat[2]),  .wbs_ack_o(wbs_ack[2])
  );

endmodule

`default_nettype wire

/* src/wb_reg_slave.sv */
`default_nettype none

module wb_reg_slave
  import wb_bus_pkg::*;
#(
  parameter int ACK_DELAY = 1
) (
  input  wire          wb_clk_i,
  input  wire          wb_rst_i,
  input  wire          wbs_cyc_i,
  input  wire          wbs_stb_i,
  input  wire          wbs_we_i,
  input  wire wb_sel_t wbs_sel_i,
  input  wire wb_adr_t wbs_adr_i,
  input  wire wb_dat_t wbs_dat_i,
  output wb_dat_t      wbs_dat_o,
  output logic         wbs_ack_o
);

  wb_dat_t                regs [16];
  logic [3:0]             word_idx;
  logic                   req;
  logic [ACK_DELAY-1:0]   ack_sr;   // one bit per delay cycle
  logic                   pending;

  assign req      = wbs_cyc_i & wbs_stb_i;
  assign word_idx = wbs_adr_i[4:1];  // upper bits alias

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      for (int w = 0; w < 16; w++) begin
        regs[w] <= '0;
      end
    end else if (req && wbs_we_i) begin
      for (int b = 0; b < 2; b++) begin
        if (wbs_sel_i[b]) begin
          regs[word_idx][8*b +: 8] <= wbs_dat_i[8*b +: 8];
        end
      end
    end
  end

  // read data stays put until the next read strobe
  always_ff @(posedge wb_clk_i) begin
    if (req && !wbs_we_i) begin
      wbs_dat_o <= regs[word_idx];
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_sr  <= '0;
      pending <= 1'b0;
    end else begin
      ack_sr <= (ack_sr << 1) | ACK_DELAY'(req);
      if (req) begin
        pending <= 1'b1;
      end else if (wbs_ack_o) begin
        pending <= 1'b0;
      end
    end
  end

  assign wbs_ack_o = ack_sr[ACK_DELAY-1];

  a_ack_needs_req : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wbs_ack_o |-> pending);

endmodule

`default_nettype wire

/* wb_decoder/addr_window_match.sv */
`default_nettype none

module addr_window_match
  import wb_bus_pkg::*;
#(
  parameter int NUM_SLAVES = NUM_WINDOWS
) (
  input  wire wb_adr_t    adr_i,
  output logic            hit_o,
  output slave_idx_t      idx_o,
  output wb_adr_t         rebased_adr_o
);

  wb_page_t page;
  wb_page_t base_page;   // base of the winning window

  assign page = adr_i[31:16];

  // walk from the highest slot down, so the lowest match is written last
  always_comb begin
    hit_o     = 1'b0;
    idx_o     = '0;
    base_page = '0;
    for (int i = NUM_SLAVES - 1; i >= 0; i--) begin
      if ((page >= WIN_BASE[i]) && (page <= WIN_HIGH[i])) begin
        hit_o     = 1'b1;
        idx_o     = slave_idx_t'(i);
        base_page = WIN_BASE[i];
      end
    end
  end

  // offset inside the window, lower half passes unchanged
  assign rebased_adr_o = adr_i - {base_page, 16'h0000};

endmodule

`default_nettype wire

/* wb_decoder/wb_decoder.sv */
`default_nettype none

module wb_decoder
  import wb_bus_pkg::*;
#(
  parameter int NUM_SLAVES = NUM_WINDOWS,
  parameter int TIMEOUT    = 12
) (
  input  wire                            wb_clk_i,
  input  wire                            wb_rst_i,
  // master side
  input  wire                            wbm_cyc_i,
  input  wire                            wbm_stb_i,
  input  wire                            wbm_we_i,
  input  wire wb_sel_t                   wbm_sel_i,
  input  wire wb_adr_t                   wbm_adr_i,
  input  wire wb_dat_t                   wbm_dat_i,
  output wb_dat_t                        wbm_dat_o,
  output logic                           wbm_ack_o,
  output logic                           wbm_err_o,
  // slave side
  output logic [NUM_SLAVES-1:0]          wbs_cyc_o,
  output logic [NUM_SLAVES-1:0]          wbs_stb_o,
  output logic                           wbs_we_o,
  output wb_sel_t                        wbs_sel_o,
  output wb_adr_t                        wbs_adr_o,
  output wb_dat_t                        wbs_dat_o,
  input  wire wb_dat_t [NUM_SLAVES-1:0]  wbs_dat_i,
  input  wire [NUM_SLAVES-1:0]           wbs_ack_i
);

  typedef enum logic {
    IDLE,
    WAIT
  } dec_state_t;

  dec_state_t state;

  logic                  match_hit;
  slave_idx_t            match_idx;
  wb_adr_t               match_adr;

  logic                  act_hit;   // latched at request
  slave_idx_t            act_idx;
  logic [NUM_SLAVES-1:0] strobe;

  logic                  wd_clear;
  logic                  wd_expired;
  logic                  req;
  logic                  slave_ack;

  addr_window_match #(
    .NUM_SLAVES(NUM_SLAVES)
  ) i_match (
    .adr_i         (wbm_adr_i),
    .hit_o         (match_hit),
    .idx_o         (match_idx),
    .rebased_adr_o (match_adr)
  );

  // counter runs only while a cycle is outstanding
  assign wd_clear = (state != WAIT);

  bus_watchdog #(
    .TIMEOUT(TIMEOUT)
  ) i_watchdog (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .clear_i   (wd_clear),
    .expired_o (wd_expired)
  );

  assign req       = wbm_cyc_i & wbm_stb_i;
  assign slave_ack = act_hit & wbs_ack_i[act_idx];

  // request fields are held by the master for the whole cycle
  assign wbs_we_o  = wbm_we_i;
  assign wbs_sel_o = wbm_sel_i;
  assign wbs_dat_o = wbm_dat_i;
  assign wbs_cyc_o = strobe;
  assign wbs_stb_o = strobe;

  always_ff @(posedge wb_clk_i) begin
    strobe    <= '0;   // one-cycle pulses by default
    wbm_ack_o <= 1'b0;
    wbm_err_o <= 1'b0;
    if (wb_rst_i) begin
      state   <= IDLE;
      act_hit <= 1'b0;
      act_idx <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req) begin
            act_hit <= match_hit;
            act_idx <= match_idx;
            strobe  <= match_hit ? (NUM_SLAVES'(1) << match_idx) : '0;  // none on a miss
            state   <= WAIT;
          end
        end
        WAIT: begin
          if (slave_ack) begin
            wbm_ack_o <= 1'b1;
            state     <= IDLE;
          end else if (wd_expired) begin
            wbm_err_o <= 1'b1;  // no slave answered
            state     <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // slave address and returned data
  always_ff @(posedge wb_clk_i) begin
    if (state == IDLE && req) begin
      wbs_adr_o <= match_adr;
    end
    if (state == WAIT && slave_ack) begin
      wbm_dat_o <= wbs_dat_i[act_idx];
    end
  end

  a_strobe_onehot : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    $onehot0(wbs_stb_o));

  a_ack_err_excl : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !(wbm_ack_o && wbm_err_o));

  // slaves only answer a strobe issued by this FSM
  a_ack_in_wait : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (state != WAIT) |-> (wbs_ack_i == '0));

endmodule

`default_nettype wire
